//--- hw/cap_alu_pkg.sv
package cap_alu_pkg;

  ////////////////////////////////////////
  // widths and limits
  ////////////////////////////////////////

  // integer and address width
  localparam int unsigned IntWidth   = 32;
  localparam int unsigned PermsWidth = 8;
  localparam int unsigned OTypeWidth = 4;
  // object types above this one are reserved
  localparam int unsigned MaxOType   = 11;

  // bit positions inside the permissions field
  localparam int unsigned PermitGlobalIndex = 0;
  localparam int unsigned PermitSealIndex   = 1;
  localparam int unsigned PermitUnsealIndex = 2;

  // uncompressed capability, 111 bits, tag in the top bit
  typedef struct packed {
    logic                  tag;
    logic [PermsWidth-1:0] perms;
    logic                  sealed;
    logic [OTypeWidth-1:0] otype;
    logic [IntWidth-1:0]   base;
    // top needs one extra bit to reach the end of the address space
    logic [IntWidth:0]     top;
    logic [IntWidth-1:0]   addr;
  } cap_t;

  typedef enum logic [3:0] {
    OP_GET_BASE   = 4'h0,
    OP_GET_LEN    = 4'h1,
    OP_GET_ADDR   = 4'h2,
    OP_GET_TAG    = 4'h3,
    OP_GET_PERM   = 4'h4,
    OP_SET_ADDR   = 4'h5,
    OP_INC_OFFSET = 4'h6,
    OP_AND_PERM   = 4'h7,
    OP_CLEAR_TAG  = 4'h8,
    OP_SEAL       = 4'h9,
    OP_UNSEAL     = 4'hA
  } cap_op_e;

  // bit index of each violation in an exception vector
  typedef enum int unsigned {
    EXC_TAG           = 0,
    EXC_SEAL          = 1,
    EXC_LENGTH        = 2,
    EXC_TYPE          = 3,
    EXC_PERMIT_SEAL   = 4,
    EXC_PERMIT_UNSEAL = 5
  } cap_exc_e;

  localparam int unsigned ExcWidth = 6;

  typedef logic [ExcWidth-1:0] cap_exc_t;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_EXEC = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_e;

endpackage

//--- hw/cap_field_decode.sv
`timescale 1ns/1ps

module cap_field_decode (
  input  cap_alu_pkg::cap_t                cap_i,
  output logic [cap_alu_pkg::IntWidth-1:0] offset_o,
  output logic [cap_alu_pkg::IntWidth-1:0] length_o,
  output logic                             addr_below_base_o,
  output logic                             addr_at_or_above_top_o
);

  // full 33-bit length before saturation
  logic [cap_alu_pkg::IntWidth:0] length_full;

  // offset wraps like the address does
  assign offset_o = cap_i.addr - cap_i.base;

  assign length_full = cap_i.top - {1'b0, cap_i.base};

  // a length of 2^32 does not fit, report all ones instead
  assign length_o = length_full[cap_alu_pkg::IntWidth] ?
                    {cap_alu_pkg::IntWidth{1'b1}} :
                    length_full[cap_alu_pkg::IntWidth-1:0];

  // bounds tests, top is exclusive
  assign addr_below_base_o      = cap_i.addr < cap_i.base;
  assign addr_at_or_above_top_o = {1'b0, cap_i.addr} >= cap_i.top;

endmodule

//--- hw/cap_violation_check.sv
`timescale 1ns/1ps

module cap_violation_check (
  input  cap_alu_pkg::cap_op_e  op_i,
  input  cap_alu_pkg::cap_t     cap_a_i,
  input  cap_alu_pkg::cap_t     cap_b_i,
  input  logic                  b_addr_below_base_i,
  input  logic                  b_addr_at_or_above_top_i,
  output cap_alu_pkg::cap_exc_t exc_a_o,
  output cap_alu_pkg::cap_exc_t exc_b_o
);

  cap_alu_pkg::cap_exc_t common_a;
  cap_alu_pkg::cap_exc_t common_b;
  logic                  b_otype_too_big;
  logic                  b_type_mismatch;

  ////////////////////////////////////////
  // common violations
  ////////////////////////////////////////

  always_comb begin
    common_a = '0;
    common_b = '0;
    common_a[cap_alu_pkg::EXC_TAG]  = ~cap_a_i.tag;
    common_b[cap_alu_pkg::EXC_TAG]  = ~cap_b_i.tag;
    // sealed only counts when the tag is set
    common_a[cap_alu_pkg::EXC_SEAL] = cap_a_i.tag & cap_a_i.sealed;
    common_b[cap_alu_pkg::EXC_SEAL] = cap_b_i.tag & cap_b_i.sealed;
    // b is the authority for seal and unseal, so only b has bounds and perms checked
    common_b[cap_alu_pkg::EXC_LENGTH] = b_addr_below_base_i | b_addr_at_or_above_top_i;
    common_b[cap_alu_pkg::EXC_PERMIT_SEAL] =
      ~cap_b_i.perms[cap_alu_pkg::PermitSealIndex];
    common_b[cap_alu_pkg::EXC_PERMIT_UNSEAL] =
      ~cap_b_i.perms[cap_alu_pkg::PermitUnsealIndex];
  end

  // object type selected by b must not be reserved
  assign b_otype_too_big = cap_b_i.addr > cap_alu_pkg::IntWidth'(cap_alu_pkg::MaxOType);

  // unseal key has to name the type a was sealed with
  assign b_type_mismatch = cap_b_i.addr !=
    {{(cap_alu_pkg::IntWidth-cap_alu_pkg::OTypeWidth){1'b0}}, cap_a_i.otype};

  ////////////////////////////////////////
  // per-opcode selection
  ////////////////////////////////////////

  always_comb begin
    exc_a_o = '0;
    exc_b_o = '0;
    case (op_i)
      cap_alu_pkg::OP_SET_ADDR, cap_alu_pkg::OP_INC_OFFSET: begin
        exc_a_o[cap_alu_pkg::EXC_SEAL] = common_a[cap_alu_pkg::EXC_SEAL];
      end
      cap_alu_pkg::OP_AND_PERM: begin
        exc_a_o[cap_alu_pkg::EXC_TAG]  = common_a[cap_alu_pkg::EXC_TAG];
        exc_a_o[cap_alu_pkg::EXC_SEAL] = cap_a_i.sealed;
      end
      cap_alu_pkg::OP_SEAL: begin
        exc_a_o[cap_alu_pkg::EXC_TAG]  = common_a[cap_alu_pkg::EXC_TAG];
        exc_a_o[cap_alu_pkg::EXC_SEAL] = common_a[cap_alu_pkg::EXC_SEAL];
        exc_b_o[cap_alu_pkg::EXC_TAG]  = common_b[cap_alu_pkg::EXC_TAG];
        exc_b_o[cap_alu_pkg::EXC_SEAL] = common_b[cap_alu_pkg::EXC_SEAL];
        exc_b_o[cap_alu_pkg::EXC_PERMIT_SEAL] = common_b[cap_alu_pkg::EXC_PERMIT_SEAL];
        exc_b_o[cap_alu_pkg::EXC_LENGTH] = common_b[cap_alu_pkg::EXC_LENGTH] | b_otype_too_big;
      end
      cap_alu_pkg::OP_UNSEAL: begin
        exc_a_o[cap_alu_pkg::EXC_TAG]  = common_a[cap_alu_pkg::EXC_TAG];
        // a must already be sealed
        exc_a_o[cap_alu_pkg::EXC_SEAL] = ~cap_a_i.sealed;
        exc_b_o[cap_alu_pkg::EXC_TAG]  = common_b[cap_alu_pkg::EXC_TAG];
        exc_b_o[cap_alu_pkg::EXC_SEAL] = cap_b_i.sealed;
        exc_b_o[cap_alu_pkg::EXC_TYPE] = b_type_mismatch;
        exc_b_o[cap_alu_pkg::EXC_PERMIT_UNSEAL] = common_b[cap_alu_pkg::EXC_PERMIT_UNSEAL];
        exc_b_o[cap_alu_pkg::EXC_LENGTH] = common_b[cap_alu_pkg::EXC_LENGTH];
      end
      // field reads and clear-tag never trap
      default: begin
      end
    endcase
  end

endmodule

//--- hw/cap_modify_unit.sv
`timescale 1ns/1ps

module cap_modify_unit (
  input  cap_alu_pkg::cap_op_e             op_i,
  input  cap_alu_pkg::cap_t                cap_a_i,
  input  cap_alu_pkg::cap_t                cap_b_i,
  input  logic [cap_alu_pkg::IntWidth-1:0] a_offset_i,
  input  logic [cap_alu_pkg::IntWidth-1:0] a_length_i,
  output cap_alu_pkg::cap_t                result_o,
  output logic                             wrote_cap_o
);

  logic [cap_alu_pkg::IntWidth-1:0] inc_addr;
  logic                             keep_tag;

  // new address rebuilt from base plus the moved offset
  assign inc_addr = cap_a_i.base + (a_offset_i + cap_b_i.addr);

  // address edits drop the tag of a sealed capability
  assign keep_tag = cap_a_i.tag & ~cap_a_i.sealed;

  always_comb begin
    result_o    = '0;
    wrote_cap_o = 1'b0;
    case (op_i)
      ////////////////////////////////////////
      // field reads, integer in addr
      ////////////////////////////////////////
      cap_alu_pkg::OP_GET_BASE: begin
        result_o.addr = cap_a_i.base;
      end
      cap_alu_pkg::OP_GET_LEN: begin
        // already saturated by the decoder
        result_o.addr = a_length_i;
      end
      cap_alu_pkg::OP_GET_ADDR: begin
        result_o.addr = cap_a_i.addr;
      end
      cap_alu_pkg::OP_GET_TAG: begin
        result_o.addr = {{(cap_alu_pkg::IntWidth-1){1'b0}}, cap_a_i.tag};
      end
      cap_alu_pkg::OP_GET_PERM: begin
        result_o.addr = {{(cap_alu_pkg::IntWidth-cap_alu_pkg::PermsWidth){1'b0}},
                         cap_a_i.perms};
      end

      ////////////////////////////////////////
      // capability edits
      ////////////////////////////////////////
      cap_alu_pkg::OP_SET_ADDR: begin
        result_o      = cap_a_i;
        result_o.addr = cap_b_i.addr;
        result_o.tag  = keep_tag;
        wrote_cap_o   = 1'b1;
      end
      cap_alu_pkg::OP_INC_OFFSET: begin
        result_o      = cap_a_i;
        result_o.addr = inc_addr;
        result_o.tag  = keep_tag;
        wrote_cap_o   = 1'b1;
      end
      cap_alu_pkg::OP_AND_PERM: begin
        // mask comes from the low bits of b as an integer
        result_o       = cap_a_i;
        result_o.perms = cap_a_i.perms & cap_b_i.addr[cap_alu_pkg::PermsWidth-1:0];
        wrote_cap_o    = 1'b1;
      end
      cap_alu_pkg::OP_CLEAR_TAG: begin
        result_o     = cap_a_i;
        result_o.tag = 1'b0;
        wrote_cap_o  = 1'b1;
      end

      ////////////////////////////////////////
      // seal and unseal
      ////////////////////////////////////////
      cap_alu_pkg::OP_SEAL: begin
        result_o        = cap_a_i;
        result_o.sealed = 1'b1;
        result_o.otype  = cap_b_i.addr[cap_alu_pkg::OTypeWidth-1:0];
        wrote_cap_o     = 1'b1;
      end
      cap_alu_pkg::OP_UNSEAL: begin
        result_o        = cap_a_i;
        result_o.sealed = 1'b0;
        result_o.otype  = '0;
        // global survives only if both sides grant it
        result_o.perms[cap_alu_pkg::PermitGlobalIndex] =
          cap_a_i.perms[cap_alu_pkg::PermitGlobalIndex] &
          cap_b_i.perms[cap_alu_pkg::PermitGlobalIndex];
        wrote_cap_o     = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hw/cap_alu_ctrl.sv
`timescale 1ns/1ps

module cap_alu_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_i,
  input  cap_alu_pkg::cap_op_e  op_i,
  input  cap_alu_pkg::cap_t     cap_a_i,
  input  cap_alu_pkg::cap_t     cap_b_i,
  output cap_alu_pkg::cap_op_e  op_q_o,
  output cap_alu_pkg::cap_t     cap_a_q_o,
  output cap_alu_pkg::cap_t     cap_b_q_o,
  input  cap_alu_pkg::cap_t     result_d_i,
  input  logic                  wrote_cap_d_i,
  input  cap_alu_pkg::cap_exc_t exc_a_d_i,
  input  cap_alu_pkg::cap_exc_t exc_b_d_i,
  output logic                  ack_o,
  output cap_alu_pkg::cap_t     result_o,
  output logic                  wrote_cap_o,
  output cap_alu_pkg::cap_exc_t exc_a_o,
  output cap_alu_pkg::cap_exc_t exc_b_o
);

  cap_alu_pkg::ctrl_state_e state_q;
  cap_alu_pkg::ctrl_state_e state_d;
  logic                     accept;

  ////////////////////////////////////////
  // four-phase handshake FSM
  ////////////////////////////////////////

  // new request only taken from idle
  assign accept = (state_q == cap_alu_pkg::ST_IDLE) && req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cap_alu_pkg::ST_IDLE: if (req_i) state_d = cap_alu_pkg::ST_EXEC;
      // datapath settles in one cycle
      cap_alu_pkg::ST_EXEC: state_d = cap_alu_pkg::ST_DONE;
      // wait for the requester to drop req
      cap_alu_pkg::ST_DONE: if (!req_i) state_d = cap_alu_pkg::ST_IDLE;
      default:              state_d = cap_alu_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= cap_alu_pkg::ST_IDLE;
      ack_o       <= 1'b0;
      result_o    <= '0;
      wrote_cap_o <= 1'b0;
      exc_a_o     <= '0;
      exc_b_o     <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == cap_alu_pkg::ST_EXEC) begin
        // results held until the next request finishes
        ack_o       <= 1'b1;
        result_o    <= result_d_i;
        wrote_cap_o <= wrote_cap_d_i;
        exc_a_o     <= exc_a_d_i;
        exc_b_o     <= exc_b_d_i;
      end else if (state_q == cap_alu_pkg::ST_DONE && !req_i) begin
        ack_o <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // operand capture
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q_o    <= op_i;
      cap_a_q_o <= cap_a_i;
      cap_b_q_o <= cap_b_i;
    end
  end

endmodule

//--- hw/cap_alu_top.sv
`timescale 1ns/1ps

module cap_alu_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_i,
  input  cap_alu_pkg::cap_op_e  op_i,
  input  cap_alu_pkg::cap_t     cap_a_i,
  input  cap_alu_pkg::cap_t     cap_b_i,
  output logic                  ack_o,
  output cap_alu_pkg::cap_t     result_o,
  output logic                  wrote_cap_o,
  output cap_alu_pkg::cap_exc_t exc_a_o,
  output cap_alu_pkg::cap_exc_t exc_b_o
);

  // operands held by the control block for the whole transaction
  cap_alu_pkg::cap_op_e  op_q;
  cap_alu_pkg::cap_t     cap_a_q;
  cap_alu_pkg::cap_t     cap_b_q;

  // decoded fields
  logic [cap_alu_pkg::IntWidth-1:0] a_offset;
  logic [cap_alu_pkg::IntWidth-1:0] a_length;
  logic                             b_addr_below_base;
  logic                             b_addr_at_or_above_top;

  // combinational datapath results, registered in the control block
  cap_alu_pkg::cap_t     result_d;
  logic                  wrote_cap_d;
  cap_alu_pkg::cap_exc_t exc_a_d;
  cap_alu_pkg::cap_exc_t exc_b_d;

  cap_alu_ctrl ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .op_i          (op_i),
    .cap_a_i       (cap_a_i),
    .cap_b_i       (cap_b_i),
    .op_q_o        (op_q),
    .cap_a_q_o     (cap_a_q),
    .cap_b_q_o     (cap_b_q),
    .result_d_i    (result_d),
    .wrote_cap_d_i (wrote_cap_d),
    .exc_a_d_i     (exc_a_d),
    .exc_b_d_i     (exc_b_d),
    .ack_o         (ack_o),
    .result_o      (result_o),
    .wrote_cap_o   (wrote_cap_o),
    .exc_a_o       (exc_a_o),
    .exc_b_o       (exc_b_o)
  );

  // a only needs offset and length, b only its bounds tests
  cap_field_decode decode_a (
    .cap_i                  (cap_a_q),
    .offset_o               (a_offset),
    .length_o               (a_length),
    .addr_below_base_o      (),
    .addr_at_or_above_top_o ()
  );

  cap_field_decode decode_b (
    .cap_i                  (cap_b_q),
    .offset_o               (),
    .length_o               (),
    .addr_below_base_o      (b_addr_below_base),
    .addr_at_or_above_top_o (b_addr_at_or_above_top)
  );

  cap_violation_check viol_check (
    .op_i                     (op_q),
    .cap_a_i                  (cap_a_q),
    .cap_b_i                  (cap_b_q),
    .b_addr_below_base_i      (b_addr_below_base),
    .b_addr_at_or_above_top_i (b_addr_at_or_above_top),
    .exc_a_o                  (exc_a_d),
    .exc_b_o                  (exc_b_d)
  );

  cap_modify_unit modify (
    .op_i        (op_q),
    .cap_a_i     (cap_a_q),
    .cap_b_i     (cap_b_q),
    .a_offset_i  (a_offset),
    .a_length_i  (a_length),
    .result_o    (result_d),
    .wrote_cap_o (wrote_cap_d)
  );

endmodule

//--- sim/cap_alu_checker.sv
`timescale 1ns/1ps

module cap_alu_checker (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  req_i,
  input logic                  ack_i,
  input cap_alu_pkg::cap_t     result_i,
  input cap_alu_pkg::cap_exc_t exc_a_i,
  input cap_alu_pkg::cap_exc_t exc_b_i
);

  // number of failed assertions, read by the testbench at the end of each transaction
  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // handshake properties
  ////////////////////////////////////////

  ack_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !ack_i)
    else begin
      fail_count++;
      $error("ack high in the cycle after reset");
    end

  // ack only answers a request seen on the edge before
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
    else begin
      fail_count++;
      $error("ack rose without a request");
    end

  ack_held_while_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i && req_i) |=> ack_i)
    else begin
      fail_count++;
      $error("ack dropped while req still high");
    end

  // outputs frozen for the whole ack phase
  outputs_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i && $past(ack_i)) |-> ($stable(result_i) && $stable(exc_a_i) && $stable(exc_b_i)))
    else begin
      fail_count++;
      $error("outputs changed while ack high");
    end

endmodule

bind cap_alu_ctrl cap_alu_checker hs_assert (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .result_i (result_o),
  .exc_a_i  (exc_a_o),
  .exc_b_i  (exc_b_o)
);

//--- sim/cap_alu_tb.sv
`timescale 1ns/1ps

module cap_alu_tb;

  // edges allowed for any single wait
  localparam int unsigned AckTimeout = 20;

  logic                  clk_i;
  logic                  rst_i;
  logic                  req_i;
  cap_alu_pkg::cap_op_e  op_i;
  cap_alu_pkg::cap_t     cap_a_i;
  cap_alu_pkg::cap_t     cap_b_i;
  logic                  ack_o;
  cap_alu_pkg::cap_t     result_o;
  logic                  wrote_cap_o;
  cap_alu_pkg::cap_exc_t exc_a_o;
  cap_alu_pkg::cap_exc_t exc_b_o;

  integer seed;

  cap_alu_top cap_alu_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .cap_a_i     (cap_a_i),
    .cap_b_i     (cap_b_i),
    .ack_o       (ack_o),
    .result_o    (result_o),
    .wrote_cap_o (wrote_cap_o),
    .exc_a_o     (exc_a_o),
    .exc_b_o     (exc_b_o)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_cap(input string name, input cap_alu_pkg::cap_t exp,
                           input cap_alu_pkg::cap_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_exc(input string name, input cap_alu_pkg::cap_exc_t exp,
                           input cap_alu_pkg::cap_exc_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic void ref_alu(
    input  cap_alu_pkg::cap_op_e  op,
    input  cap_alu_pkg::cap_t     a,
    input  cap_alu_pkg::cap_t     b,
    output cap_alu_pkg::cap_t     res,
    output logic                  wrote,
    output cap_alu_pkg::cap_exc_t ea,
    output cap_alu_pkg::cap_exc_t eb
  );
    logic [cap_alu_pkg::IntWidth:0] len;
    logic                           b_oob;
    res   = '0;
    wrote = 1'b0;
    ea    = '0;
    eb    = '0;
    // 33-bit length, anything needing bit 32 reads as all ones
    len   = a.top - {1'b0, a.base};
    // b bounds, top exclusive
    b_oob = (b.addr < b.base) || ({1'b0, b.addr} >= b.top);
    case (op)
      cap_alu_pkg::OP_GET_BASE: res.addr = a.base;
      cap_alu_pkg::OP_GET_LEN: begin
        res.addr = len[cap_alu_pkg::IntWidth] ? {cap_alu_pkg::IntWidth{1'b1}} :
                   len[cap_alu_pkg::IntWidth-1:0];
      end
      cap_alu_pkg::OP_GET_ADDR: res.addr = a.addr;
      cap_alu_pkg::OP_GET_TAG:  res.addr = cap_alu_pkg::IntWidth'(a.tag);
      cap_alu_pkg::OP_GET_PERM: res.addr = cap_alu_pkg::IntWidth'(a.perms);
      cap_alu_pkg::OP_SET_ADDR, cap_alu_pkg::OP_INC_OFFSET: begin
        res      = a;
        res.addr = (op == cap_alu_pkg::OP_SET_ADDR) ? b.addr : a.addr + b.addr;
        res.tag  = a.tag && !a.sealed;
        wrote    = 1'b1;
        ea[cap_alu_pkg::EXC_SEAL] = a.tag && a.sealed;
      end
      cap_alu_pkg::OP_AND_PERM: begin
        res       = a;
        res.perms = a.perms & b.addr[cap_alu_pkg::PermsWidth-1:0];
        wrote     = 1'b1;
        ea[cap_alu_pkg::EXC_TAG]  = !a.tag;
        ea[cap_alu_pkg::EXC_SEAL] = a.sealed;
      end
      cap_alu_pkg::OP_CLEAR_TAG: begin
        res     = a;
        res.tag = 1'b0;
        wrote   = 1'b1;
      end
      cap_alu_pkg::OP_SEAL: begin
        res        = a;
        res.sealed = 1'b1;
        res.otype  = b.addr[cap_alu_pkg::OTypeWidth-1:0];
        wrote      = 1'b1;
        ea[cap_alu_pkg::EXC_TAG]  = !a.tag;
        ea[cap_alu_pkg::EXC_SEAL] = a.tag && a.sealed;
        eb[cap_alu_pkg::EXC_TAG]  = !b.tag;
        eb[cap_alu_pkg::EXC_SEAL] = b.tag && b.sealed;
        eb[cap_alu_pkg::EXC_PERMIT_SEAL] = !b.perms[cap_alu_pkg::PermitSealIndex];
        eb[cap_alu_pkg::EXC_LENGTH] = b_oob || (b.addr > cap_alu_pkg::MaxOType);
      end
      cap_alu_pkg::OP_UNSEAL: begin
        res        = a;
        res.sealed = 1'b0;
        res.otype  = '0;
        // global kept only when both grant it
        res.perms[cap_alu_pkg::PermitGlobalIndex] =
          a.perms[cap_alu_pkg::PermitGlobalIndex] && b.perms[cap_alu_pkg::PermitGlobalIndex];
        wrote      = 1'b1;
        ea[cap_alu_pkg::EXC_TAG]  = !a.tag;
        ea[cap_alu_pkg::EXC_SEAL] = !a.sealed;
        eb[cap_alu_pkg::EXC_TAG]  = !b.tag;
        eb[cap_alu_pkg::EXC_SEAL] = b.sealed;
        eb[cap_alu_pkg::EXC_TYPE] = b.addr != cap_alu_pkg::IntWidth'(a.otype);
        eb[cap_alu_pkg::EXC_PERMIT_UNSEAL] = !b.perms[cap_alu_pkg::PermitUnsealIndex];
        eb[cap_alu_pkg::EXC_LENGTH] = b_oob;
      end
      default: begin
      end
    endcase
  endfunction

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic cap_alu_pkg::cap_t make_cap(
    input logic tag, input logic [7:0] perms, input logic sealed, input logic [3:0] otype,
    input logic [31:0] base, input logic [32:0] top, input logic [31:0] addr
  );
    cap_alu_pkg::cap_t c;
    c.tag    = tag;
    c.perms  = perms;
    c.sealed = sealed;
    c.otype  = otype;
    c.base   = base;
    c.top    = top;
    c.addr   = addr;
    return c;
  endfunction

  function automatic cap_alu_pkg::cap_t rand_cap();
    cap_alu_pkg::cap_t c;
    logic [31:0]       r;
    logic [31:0]       s;
    r        = $random(seed);
    s        = $random(seed);
    c.tag    = r[0];
    c.sealed = r[1];
    c.otype  = r[7:4];
    c.perms  = r[15:8];
    c.base   = s;
    s        = $random(seed);
    // mostly sane bounds, sometimes arbitrary ones
    if (r[31]) begin
      c.top = {1'b0, c.base} + {17'd0, s[15:0]};
    end else begin
      c.top = {r[2], s};
    end
    // small addresses hit the otype and type checks
    if (r[30]) begin
      c.addr = {28'd0, r[19:16]};
    end else begin
      c.addr = c.base + {24'd0, s[23:16]};
    end
    return c;
  endfunction

  task automatic compare_outputs(input string name, input cap_alu_pkg::cap_t res,
                                 input logic wrote, input cap_alu_pkg::cap_exc_t ea,
                                 input cap_alu_pkg::cap_exc_t eb);
    check_bit({name, " ack"}, 1'b1, ack_o);
    check_cap({name, " result"}, res, result_o);
    check_bit({name, " wrote_cap"}, wrote, wrote_cap_o);
    check_exc({name, " exc_a"}, ea, exc_a_o);
    check_exc({name, " exc_b"}, eb, exc_b_o);
  endtask

  // one four-phase transaction, req held hold extra cycles after ack
  task automatic run_op(input string name, input cap_alu_pkg::cap_op_e op,
                        input cap_alu_pkg::cap_t a, input cap_alu_pkg::cap_t b,
                        input int unsigned hold);
    cap_alu_pkg::cap_t     exp_res;
    logic                  exp_wrote;
    cap_alu_pkg::cap_exc_t exp_a;
    cap_alu_pkg::cap_exc_t exp_b;
    int unsigned           edges;
    int unsigned           k;
    ref_alu(op, a, b, exp_res, exp_wrote, exp_a, exp_b);
    @(posedge clk_i);
    req_i   <= 1'b1;
    op_i    <= op;
    cap_a_i <= a;
    cap_b_i <= b;
    // count rising edges after the drive edge, sample half a cycle later
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
      if (!ack_o && edges >= AckTimeout) begin
        stop_on_error({name, ": timeout, ack never rose"});
      end
    end while (!ack_o);
    if (edges != 2) begin
      stop_on_error($sformatf("%s: ack rose after %0d edges, not 2", name, edges));
    end
    compare_outputs(name, exp_res, exp_wrote, exp_a, exp_b);
    // back-pressure, outputs must stay frozen
    for (k = 0; k < hold; k++) begin
      @(negedge clk_i);
      compare_outputs({name, " held"}, exp_res, exp_wrote, exp_a, exp_b);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    edges = 0;
    do begin
      @(negedge clk_i);
      edges++;
      if (ack_o && edges >= AckTimeout) begin
        stop_on_error({name, ": timeout, ack never fell"});
      end
    end while (ack_o);
    // result kept between requests
    check_cap({name, " after ack"}, exp_res, result_o);
    if (cap_alu_top_inst.ctrl.hs_assert.fail_count != 0) begin
      stop_on_error({name, ": a handshake assertion failed"});
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    cap_alu_pkg::cap_t a;
    cap_alu_pkg::cap_t b;
    logic [31:0]       r;
    int unsigned       i;
    seed    = 32'h4b53146a;
    rst_i   <= 1'b1;
    req_i   <= 1'b0;
    op_i    <= cap_alu_pkg::OP_GET_BASE;
    cap_a_i <= '0;
    cap_b_i <= '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_bit("reset ack", 1'b0, ack_o);
    check_bit("reset wrote_cap", 1'b0, wrote_cap_o);
    check_cap("reset result", '0, result_o);
    check_exc("reset exc_a", '0, exc_a_o);
    check_exc("reset exc_b", '0, exc_b_o);
    run_op("first get_addr", cap_alu_pkg::OP_GET_ADDR, rand_cap(), rand_cap(), 0);

    // every field read on a few random operands
    for (i = 0; i < 15; i++) begin
      run_op($sformatf("read %0d", i), cap_alu_pkg::cap_op_e'(i % 5), rand_cap(), '0, 0);
    end

    // random opcodes and operands with random back-pressure
    for (i = 0; i < 150; i++) begin
      r = $unsigned($random(seed)) % 11;
      a = rand_cap();
      b = rand_cap();
      run_op($sformatf("random %0d", i), cap_alu_pkg::cap_op_e'(r[3:0]), a, b,
             $unsigned($random(seed)) % 7);
    end

    // saturated length
    a = make_cap(1, 8'hFF, 0, 0, 32'h0, 33'h1_0000_0000, 32'h40);
    run_op("length saturated", cap_alu_pkg::OP_GET_LEN, a, '0, 1);

    // seal, clean and each b violation
    a = make_cap(1, 8'hFF, 0, 0, 32'h1000, 33'h2000, 32'h1800);
    b = make_cap(1, 8'h06, 0, 0, 32'h0, 33'h10, 32'h5);
    run_op("seal clean", cap_alu_pkg::OP_SEAL, a, b, 0);
    b.addr = 32'hC;
    run_op("seal reserved otype", cap_alu_pkg::OP_SEAL, a, b, 2);
    b = make_cap(1, 8'h04, 0, 0, 32'h0, 33'h10, 32'h5);
    run_op("seal no permit", cap_alu_pkg::OP_SEAL, a, b, 0);
    b = make_cap(1, 8'h06, 0, 0, 32'h0, 33'h4, 32'h5);
    run_op("seal b out of bounds", cap_alu_pkg::OP_SEAL, a, b, 0);
    a.sealed = 1'b1;
    run_op("seal a sealed", cap_alu_pkg::OP_SEAL, a, b, 0);

    // unseal, clean, global drop, type mismatch, a not sealed
    a = make_cap(1, 8'h81, 1, 4'h5, 32'h1000, 33'h2000, 32'h1800);
    b = make_cap(1, 8'h05, 0, 0, 32'h0, 33'h10, 32'h5);
    run_op("unseal clean", cap_alu_pkg::OP_UNSEAL, a, b, 0);
    b.perms = 8'h04;
    run_op("unseal drops global", cap_alu_pkg::OP_UNSEAL, a, b, 3);
    b.addr = 32'h6;
    run_op("unseal type mismatch", cap_alu_pkg::OP_UNSEAL, a, b, 0);
    a.sealed = 1'b0;
    run_op("unseal a not sealed", cap_alu_pkg::OP_UNSEAL, a, b, 0);

    if (cap_alu_top_inst.ctrl.hs_assert.fail_count != 0) begin
      stop_on_error("a handshake assertion failed");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- all.f
hw/cap_alu_pkg.sv
hw/cap_field_decode.sv
hw/cap_violation_check.sv
hw/cap_modify_unit.sv
hw/cap_alu_ctrl.sv
hw/cap_alu_top.sv
sim/cap_alu_checker.sv
sim/cap_alu_tb.sv
